//--- src/xform_pkg.sv
package xform_pkg;

    // signed q16.16 number format.
    localparam int q_w    = 32;
    localparam int q_frac = 16;

    // 1.0 in q16.16.
    localparam logic signed [q_w-1:0] q_one = 32'sh0001_0000;

    // rotation matrix builder states.
    typedef enum logic [1:0] {
        BLD_IDLE = 2'd0,
        BLD_PROD = 2'd1,
        BLD_DONE = 2'd2
    } bld_state_t;

    // vertex sequencer states.
    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_SEND = 1'b1
    } seq_state_t;

    // q16.16 multiply with a full-width product and a truncating shift.
    // the result wraps to 32 bits.
    function automatic logic signed [q_w-1:0] q_mul(
        input logic signed [q_w-1:0] a,
        input logic signed [q_w-1:0] b
    );
        logic signed [2*q_w-1:0] full;
        logic signed [2*q_w-1:0] shifted;
        full    = a * b;
        shifted = full >>> q_frac;
        return shifted[q_w-1:0];
    endfunction

endpackage

//--- src/rot_matrix_builder.sv
`timescale 1ns/1ps

module rot_matrix_builder (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             accept,
    input  logic signed [xform_pkg::q_w-1:0] sin_x, cos_x,
    input  logic signed [xform_pkg::q_w-1:0] sin_y, cos_y,
    input  logic signed [xform_pkg::q_w-1:0] sin_z, cos_z,
    input  logic signed [xform_pkg::q_w-1:0] pos_x, pos_y, pos_z,
    output logic                             matrix_valid,
    output logic signed [xform_pkg::q_w-1:0] m00, m01, m02,
    output logic signed [xform_pkg::q_w-1:0] m10, m11, m12,
    output logic signed [xform_pkg::q_w-1:0] m20, m21, m22,
    output logic signed [xform_pkg::q_w-1:0] mpos_x, mpos_y, mpos_z
);

    xform_pkg::bld_state_t state;

    // rotation and position captured on accept.
    logic signed [xform_pkg::q_w-1:0] sx, cx, sy, cy, sz, cz;
    logic signed [xform_pkg::q_w-1:0] px, py, pz;

    // first-level products.
    logic signed [xform_pkg::q_w-1:0] p_czcy, p_szcy, p_czsy, p_szsy, p_cysx;
    logic signed [xform_pkg::q_w-1:0] p_cycx, p_szcx, p_szsx, p_czcx, p_czsx;

    always_ff @(posedge clk) begin
        if (accept) begin
            sx <= sin_x;
            cx <= cos_x;
            sy <= sin_y;
            cy <= cos_y;
            sz <= sin_z;
            cz <= cos_z;
            px <= pos_x;
            py <= pos_y;
            pz <= pos_z;
        end
    end

    always_ff @(posedge clk) begin
        if (state == xform_pkg::BLD_PROD) begin
            p_czcy <= xform_pkg::q_mul(cz, cy);
            p_szcy <= xform_pkg::q_mul(sz, cy);
            p_czsy <= xform_pkg::q_mul(cz, sy);
            p_szsy <= xform_pkg::q_mul(sz, sy);
            p_cysx <= xform_pkg::q_mul(cy, sx);
            p_cycx <= xform_pkg::q_mul(cy, cx);
            p_szcx <= xform_pkg::q_mul(sz, cx);
            p_szsx <= xform_pkg::q_mul(sz, sx);
            p_czcx <= xform_pkg::q_mul(cz, cx);
            p_czsx <= xform_pkg::q_mul(cz, sx);
        end
    end

    // the matrix resets to identity.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= xform_pkg::BLD_IDLE;
            matrix_valid <= 1'b0;
            m00          <= xform_pkg::q_one;
            m01          <= '0;
            m02          <= '0;
            m10          <= '0;
            m11          <= xform_pkg::q_one;
            m12          <= '0;
            m20          <= '0;
            m21          <= '0;
            m22          <= xform_pkg::q_one;
            mpos_x       <= '0;
            mpos_y       <= '0;
            mpos_z       <= '0;
        end else if (accept) begin
            // a new triangle invalidates the held matrix.
            state        <= xform_pkg::BLD_PROD;
            matrix_valid <= 1'b0;
        end else begin
            case (state)
                xform_pkg::BLD_PROD: begin
                    mpos_x <= px;
                    mpos_y <= py;
                    mpos_z <= pz;
                    state  <= xform_pkg::BLD_DONE;
                end
                xform_pkg::BLD_DONE: begin
                    m00          <= p_czcy;
                    m01          <= xform_pkg::q_mul(p_czsy, sx) - p_szcx;
                    m02          <= xform_pkg::q_mul(p_czsy, cx) + p_szsx;
                    m10          <= p_szcy;
                    m11          <= xform_pkg::q_mul(p_szsy, sx) + p_czcx;
                    m12          <= xform_pkg::q_mul(p_szsy, cx) - p_czsx;
                    m20          <= -sy;
                    m21          <= p_cysx;
                    m22          <= p_cycx;
                    matrix_valid <= 1'b1;
                    state        <= xform_pkg::BLD_IDLE;
                end
                default: state <= xform_pkg::BLD_IDLE;
            endcase
        end
    end

endmodule

//--- src/vertex_sequencer.sv
`timescale 1ns/1ps

module vertex_sequencer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             in_valid,
    input  logic signed [xform_pkg::q_w-1:0] v0_x, v0_y, v0_z,
    input  logic signed [xform_pkg::q_w-1:0] v1_x, v1_y, v1_z,
    input  logic signed [xform_pkg::q_w-1:0] v2_x, v2_y, v2_z,
    input  logic                             vert_ready,
    output logic                             in_ready,
    output logic                             accept,
    output logic                             vert_valid,
    output logic signed [xform_pkg::q_w-1:0] vert_x, vert_y, vert_z,
    output logic [1:0]                       vert_idx,
    output logic                             seq_busy
);

    xform_pkg::seq_state_t state;

    // held copy of the accepted triangle.
    logic signed [xform_pkg::q_w-1:0] t0_x, t0_y, t0_z;
    logic signed [xform_pkg::q_w-1:0] t1_x, t1_y, t1_z;
    logic signed [xform_pkg::q_w-1:0] t2_x, t2_y, t2_z;

    logic vert_take;

    assign in_ready   = (state == xform_pkg::SEQ_IDLE);
    assign accept     = in_valid && in_ready;
    assign vert_valid = (state == xform_pkg::SEQ_SEND);
    assign seq_busy   = vert_valid;
    assign vert_take  = vert_valid && vert_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            t0_x <= v0_x;
            t0_y <= v0_y;
            t0_z <= v0_z;
            t1_x <= v1_x;
            t1_y <= v1_y;
            t1_z <= v1_z;
            t2_x <= v2_x;
            t2_y <= v2_y;
            t2_z <= v2_z;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= xform_pkg::SEQ_IDLE;
            vert_idx <= 2'd0;
        end else if (accept) begin
            state    <= xform_pkg::SEQ_SEND;
            vert_idx <= 2'd0;
        end else if (vert_take) begin
            if (vert_idx == 2'd2) begin
                // last vertex gone, ready for the next triangle.
                state    <= xform_pkg::SEQ_IDLE;
                vert_idx <= 2'd0;
            end else begin
                vert_idx <= vert_idx + 2'd1;
            end
        end
    end

    always_comb begin
        case (vert_idx)
            2'd0: begin
                vert_x = t0_x;
                vert_y = t0_y;
                vert_z = t0_z;
            end
            2'd1: begin
                vert_x = t1_x;
                vert_y = t1_y;
                vert_z = t1_z;
            end
            default: begin
                vert_x = t2_x;
                vert_y = t2_y;
                vert_z = t2_z;
            end
        endcase
    end

endmodule

//--- src/vertex_transform.sv
`timescale 1ns/1ps

module vertex_transform (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             matrix_valid,
    input  logic signed [xform_pkg::q_w-1:0] m00, m01, m02,
    input  logic signed [xform_pkg::q_w-1:0] m10, m11, m12,
    input  logic signed [xform_pkg::q_w-1:0] m20, m21, m22,
    input  logic signed [xform_pkg::q_w-1:0] mpos_x, mpos_y, mpos_z,
    input  logic                             vert_valid,
    input  logic signed [xform_pkg::q_w-1:0] vert_x, vert_y, vert_z,
    input  logic [1:0]                       vert_idx,
    input  logic                             wv_ready,
    output logic                             vert_ready,
    output logic                             wv_valid,
    output logic signed [xform_pkg::q_w-1:0] wv_x, wv_y, wv_z,
    output logic [1:0]                       wv_idx,
    output logic                             pipe_busy
);

    logic s1_valid;
    logic s2_valid;
    logic stall;
    logic vert_take;

    // stage 1 products, position and index.
    logic signed [xform_pkg::q_w-1:0] p00, p01, p02;
    logic signed [xform_pkg::q_w-1:0] p10, p11, p12;
    logic signed [xform_pkg::q_w-1:0] p20, p21, p22;
    logic signed [xform_pkg::q_w-1:0] s1_pos_x, s1_pos_y, s1_pos_z;
    logic [1:0]                       s1_idx;

    // the whole pipeline holds while the output waits.
    assign stall      = s2_valid && !wv_ready;
    assign vert_ready = matrix_valid && !stall;
    assign vert_take  = vert_valid && vert_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= vert_take;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && vert_take) begin
            p00      <= xform_pkg::q_mul(m00, vert_x);
            p01      <= xform_pkg::q_mul(m01, vert_y);
            p02      <= xform_pkg::q_mul(m02, vert_z);
            p10      <= xform_pkg::q_mul(m10, vert_x);
            p11      <= xform_pkg::q_mul(m11, vert_y);
            p12      <= xform_pkg::q_mul(m12, vert_z);
            p20      <= xform_pkg::q_mul(m20, vert_x);
            p21      <= xform_pkg::q_mul(m21, vert_y);
            p22      <= xform_pkg::q_mul(m22, vert_z);
            // position rides along so the builder may move on.
            s1_pos_x <= mpos_x;
            s1_pos_y <= mpos_y;
            s1_pos_z <= mpos_z;
            s1_idx   <= vert_idx;
        end
    end

    // stage 2 row sums, wrapping at 32 bits.
    always_ff @(posedge clk) begin
        if (!stall && s1_valid) begin
            wv_x   <= p00 + p01 + p02 + s1_pos_x;
            wv_y   <= p10 + p11 + p12 + s1_pos_y;
            wv_z   <= p20 + p21 + p22 + s1_pos_z;
            wv_idx <= s1_idx;
        end
    end

    assign wv_valid  = s2_valid;
    assign pipe_busy = s1_valid || s2_valid;

endmodule

//--- src/triangle_assembler.sv
`timescale 1ns/1ps

module triangle_assembler (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wv_valid,
    input  logic signed [xform_pkg::q_w-1:0] wv_x, wv_y, wv_z,
    input  logic [1:0]                       wv_idx,
    input  logic                             out_ready,
    input  logic                             seq_busy,
    input  logic                             pipe_busy,
    output logic                             wv_ready,
    output logic                             out_valid,
    output logic signed [xform_pkg::q_w-1:0] out_v0_x, out_v0_y, out_v0_z,
    output logic signed [xform_pkg::q_w-1:0] out_v1_x, out_v1_y, out_v1_z,
    output logic signed [xform_pkg::q_w-1:0] out_v2_x, out_v2_y, out_v2_z,
    output logic                             busy
);

    logic store;
    // set while vertex 0 or 1 is stored and vertex 2 is still missing.
    logic partial;

    // hold off new vertices only while a full triangle waits.
    assign wv_ready = !(out_valid && !out_ready);
    assign store    = wv_valid && wv_ready;

    always_ff @(posedge clk) begin
        if (store) begin
            case (wv_idx)
                2'd0: begin
                    out_v0_x <= wv_x;
                    out_v0_y <= wv_y;
                    out_v0_z <= wv_z;
                end
                2'd1: begin
                    out_v1_x <= wv_x;
                    out_v1_y <= wv_y;
                    out_v1_z <= wv_z;
                end
                default: begin
                    out_v2_x <= wv_x;
                    out_v2_y <= wv_y;
                    out_v2_z <= wv_z;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            partial   <= 1'b0;
        end else begin
            if (store && wv_idx == 2'd2) begin
                out_valid <= 1'b1;
                partial   <= 1'b0;
            end else begin
                if (out_ready) begin
                    out_valid <= 1'b0;
                end
                if (store) begin
                    partial <= 1'b1;
                end
            end
        end
    end

    assign busy = seq_busy || pipe_busy || partial || out_valid;

endmodule

//--- src/model_world_transformer.sv
`timescale 1ns/1ps

module model_world_transformer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic signed [xform_pkg::q_w-1:0] v0_x, v0_y, v0_z,
    input  logic signed [xform_pkg::q_w-1:0] v1_x, v1_y, v1_z,
    input  logic signed [xform_pkg::q_w-1:0] v2_x, v2_y, v2_z,
    input  logic signed [xform_pkg::q_w-1:0] sin_x, cos_x, sin_y, cos_y, sin_z, cos_z,
    input  logic signed [xform_pkg::q_w-1:0] pos_x, pos_y, pos_z,
    input  logic                             in_valid,
    output logic                             in_ready,
    output logic signed [xform_pkg::q_w-1:0] out_v0_x, out_v0_y, out_v0_z,
    output logic signed [xform_pkg::q_w-1:0] out_v1_x, out_v1_y, out_v1_z,
    output logic signed [xform_pkg::q_w-1:0] out_v2_x, out_v2_y, out_v2_z,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic                             busy
);

    logic                             accept;
    logic                             matrix_valid;
    logic signed [xform_pkg::q_w-1:0] m00, m01, m02, m10, m11, m12, m20, m21, m22;
    logic signed [xform_pkg::q_w-1:0] mpos_x, mpos_y, mpos_z;
    logic                             vert_valid, vert_ready;
    logic signed [xform_pkg::q_w-1:0] vert_x, vert_y, vert_z;
    logic [1:0]                       vert_idx;
    logic                             wv_valid, wv_ready;
    logic signed [xform_pkg::q_w-1:0] wv_x, wv_y, wv_z;
    logic [1:0]                       wv_idx;
    logic                             seq_busy, pipe_busy;

    rot_matrix_builder u_rot_matrix_builder (
        .clk(clk), .rst(rst), .accept(accept),
        .sin_x(sin_x), .cos_x(cos_x), .sin_y(sin_y), .cos_y(cos_y),
        .sin_z(sin_z), .cos_z(cos_z),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z),
        .matrix_valid(matrix_valid),
        .m00(m00), .m01(m01), .m02(m02), .m10(m10), .m11(m11), .m12(m12),
        .m20(m20), .m21(m21), .m22(m22),
        .mpos_x(mpos_x), .mpos_y(mpos_y), .mpos_z(mpos_z)
    );

    vertex_sequencer u_vertex_sequencer (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .v0_x(v0_x), .v0_y(v0_y), .v0_z(v0_z),
        .v1_x(v1_x), .v1_y(v1_y), .v1_z(v1_z),
        .v2_x(v2_x), .v2_y(v2_y), .v2_z(v2_z),
        .vert_ready(vert_ready), .in_ready(in_ready), .accept(accept),
        .vert_valid(vert_valid), .vert_x(vert_x), .vert_y(vert_y), .vert_z(vert_z),
        .vert_idx(vert_idx), .seq_busy(seq_busy)
    );

    vertex_transform u_vertex_transform (
        .clk(clk), .rst(rst), .matrix_valid(matrix_valid),
        .m00(m00), .m01(m01), .m02(m02), .m10(m10), .m11(m11), .m12(m12),
        .m20(m20), .m21(m21), .m22(m22),
        .mpos_x(mpos_x), .mpos_y(mpos_y), .mpos_z(mpos_z),
        .vert_valid(vert_valid), .vert_x(vert_x), .vert_y(vert_y), .vert_z(vert_z),
        .vert_idx(vert_idx), .wv_ready(wv_ready), .vert_ready(vert_ready),
        .wv_valid(wv_valid), .wv_x(wv_x), .wv_y(wv_y), .wv_z(wv_z),
        .wv_idx(wv_idx), .pipe_busy(pipe_busy)
    );

    triangle_assembler u_triangle_assembler (
        .clk(clk), .rst(rst), .wv_valid(wv_valid),
        .wv_x(wv_x), .wv_y(wv_y), .wv_z(wv_z), .wv_idx(wv_idx),
        .out_ready(out_ready), .seq_busy(seq_busy), .pipe_busy(pipe_busy),
        .wv_ready(wv_ready), .out_valid(out_valid),
        .out_v0_x(out_v0_x), .out_v0_y(out_v0_y), .out_v0_z(out_v0_z),
        .out_v1_x(out_v1_x), .out_v1_y(out_v1_y), .out_v1_z(out_v1_z),
        .out_v2_x(out_v2_x), .out_v2_y(out_v2_y), .out_v2_z(out_v2_z),
        .busy(busy)
    );

endmodule

//--- sim/tb_xform_ref.svh
`ifndef TB_XFORM_REF_SVH
`define TB_XFORM_REF_SVH

// q16.16 product at 64 bits, arithmetic shift, low 32 bits kept.
function automatic logic signed [31:0] fixed_mul(input logic signed [31:0] a,
                                                 input logic signed [31:0] b);
    logic signed [63:0] wide;
    wide = 64'(a) * 64'(b);
    wide = wide >>> xform_pkg::q_frac;
    return wide[31:0];
endfunction

// rot holds sx, cx, sy, cy, sz, cz from index 0 up.
function automatic logic [8:0][31:0] rotation_matrix(input logic [5:0][31:0] rot);
    logic signed [31:0] sx, cx, sy, cy, sz, cz;
    logic [8:0][31:0]   m;
    sx = rot[0];
    cx = rot[1];
    sy = rot[2];
    cy = rot[3];
    sz = rot[4];
    cz = rot[5];
    m[0] = fixed_mul(cz, cy);
    m[1] = fixed_mul(fixed_mul(cz, sy), sx) - fixed_mul(sz, cx);
    m[2] = fixed_mul(fixed_mul(cz, sy), cx) + fixed_mul(sz, sx);
    m[3] = fixed_mul(sz, cy);
    m[4] = fixed_mul(fixed_mul(sz, sy), sx) + fixed_mul(cz, cx);
    m[5] = fixed_mul(fixed_mul(sz, sy), cx) - fixed_mul(cz, sx);
    m[6] = -sy;
    m[7] = fixed_mul(cy, sx);
    m[8] = fixed_mul(cy, cx);
    return m;
endfunction

// rotate each vertex of the triangle and add the position.
function automatic logic [8:0][31:0] world_triangle(input logic [8:0][31:0] vin,
                                                    input logic [5:0][31:0] rot,
                                                    input logic [2:0][31:0] pos);
    logic [8:0][31:0] m;
    logic [8:0][31:0] t;
    m = rotation_matrix(rot);
    for (int v = 0; v < 3; v++) begin
        for (int r = 0; r < 3; r++) begin
            t[3*v+r] = fixed_mul(m[3*r], vin[3*v]) + fixed_mul(m[3*r+1], vin[3*v+1])
                     + fixed_mul(m[3*r+2], vin[3*v+2]) + pos[r];
        end
    end
    return t;
endfunction

`endif

//--- sim/tb_model_world_transformer.sv
`timescale 1ns/1ps

module tb_model_world_transformer;

    `include "tb_xform_ref.svh"

    localparam int n_rand = 20;
    // five directed triangles plus two random runs.
    localparam int cycle_limit = 40 * (5 + 2 * n_rand) + 200;

    logic             clk = 1'b0;
    logic             rst;
    logic [8:0][31:0] tri_v;
    logic [5:0][31:0] rot_v;
    logic [2:0][31:0] pos_v;
    logic             in_valid;
    logic             in_ready;
    wire  [8:0][31:0] out_t;
    logic             out_valid;
    logic             out_ready = 1'b1;
    logic             busy;
    logic             random_ready = 1'b0;

    logic [8:0][31:0]   exp_q[$];
    string              current;
    int                 seed = 49292;
    int                 cycles = 0;
    int                 errors = 0;
    int                 test_errors;
    int                 test_num = 0;
    int                 test_pass = 0;
    int                 test_fail = 0;
    // sine and cosine pairs for 0, 90, 30, 45, 60, -30, 135 and -90 degrees.
    logic signed [31:0] sin_tab [8] = '{32'sh0, 32'sh1_0000, 32'sh8000, 32'shB505,
                                        32'shDDB4, 32'shFFFF_8000, 32'shB505, 32'shFFFF_0000};
    logic signed [31:0] cos_tab [8] = '{32'sh1_0000, 32'sh0, 32'shDDB4, 32'shB505,
                                        32'sh8000, 32'shDDB4, 32'shFFFF_4AFB, 32'sh0};
    string out_name [9] = '{"out_v0_x", "out_v0_y", "out_v0_z", "out_v1_x", "out_v1_y",
                            "out_v1_z", "out_v2_x", "out_v2_y", "out_v2_z"};

    model_world_transformer u_model_world_transformer (
        .clk(clk), .rst(rst),
        .v0_x(tri_v[0]), .v0_y(tri_v[1]), .v0_z(tri_v[2]),
        .v1_x(tri_v[3]), .v1_y(tri_v[4]), .v1_z(tri_v[5]),
        .v2_x(tri_v[6]), .v2_y(tri_v[7]), .v2_z(tri_v[8]),
        .sin_x(rot_v[0]), .cos_x(rot_v[1]), .sin_y(rot_v[2]), .cos_y(rot_v[3]),
        .sin_z(rot_v[4]), .cos_z(rot_v[5]),
        .pos_x(pos_v[0]), .pos_y(pos_v[1]), .pos_z(pos_v[2]),
        .in_valid(in_valid), .in_ready(in_ready),
        .out_v0_x(out_t[0]), .out_v0_y(out_t[1]), .out_v0_z(out_t[2]),
        .out_v1_x(out_t[3]), .out_v1_y(out_t[4]), .out_v1_z(out_t[5]),
        .out_v2_x(out_t[6]), .out_v2_y(out_t[7]), .out_v2_z(out_t[8]),
        .out_valid(out_valid), .out_ready(out_ready), .busy(busy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = ($unsigned($random(seed)) % 100) < 30;
        end else begin
            out_ready = 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
                     !(in_ready && u_model_world_transformer.seq_busy))
        else begin
            $display("in_ready high while the sequencer holds a triangle");
            errors++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     (out_valid && !out_ready) |=> (out_valid && $stable(out_t)))
        else begin
            $display("output triangle changed while out_valid waited");
            errors++;
        end

    // pop on each taken triangle and push on each accepted one.
    always @(posedge clk) begin : scoreboard
        logic [8:0][31:0] exp_t;
        if (!rst) begin
            assert (busy || exp_q.size() == 0) else begin
                $display("busy low with %0d triangles still expected", exp_q.size());
                errors++;
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0) else begin
                    $display("output triangle taken with none expected");
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    exp_t = exp_q.pop_front();
                    for (int k = 0; k < 9; k++) begin
                        assert (out_t[k] == exp_t[k]) else begin
                            $display("ERR %s expected %h got %h", out_name[k], exp_t[k], out_t[k]);
                            errors++;
                        end
                    end
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(world_triangle(tri_v, rot_v, pos_v));
            end
        end
    end

    task automatic begin_test(input string name);
        test_num++;
        test_errors = errors;
        current = name;
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            test_pass++;
            $display("test %0d %s ok", test_num, current);
        end else begin
            test_fail++;
            $display("test %0d %s failed with %0d errors", test_num, current, errors - test_errors);
        end
    endtask

    task automatic expect_level(input string name, input logic want, input logic got);
        assert (got == want) else begin
            $display("ERR %s expected %h got %h", name, want, got);
            errors++;
        end
    endtask

    task automatic set_identity();
        rot_v = {xform_pkg::q_one, 32'sh0, xform_pkg::q_one, 32'sh0, xform_pkg::q_one, 32'sh0};
    endtask

    // called just after a falling edge.
    task automatic send_tri();
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (busy || exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic random_triangle();
        int a;
        for (int k = 0; k < 9; k++) begin
            tri_v[k] = $random(seed);
        end
        for (int k = 0; k < 3; k++) begin
            a = $random(seed) & 7;
            rot_v[2*k]   = sin_tab[a];
            rot_v[2*k+1] = cos_tab[a];
            pos_v[k]     = $random(seed);
        end
    endtask

    initial begin
        int lat;
        rst = 1'b1;
        in_valid = 1'b0;
        rot_v = '0;
        pos_v = '0;
        tri_v = {32'sh0000_2000, 32'shFFF7_C000, 32'sh0007_8000,
                 32'shFFFA_0000, 32'sh0005_0000, 32'shFFFC_0000,
                 32'sh0003_0000, 32'sh0002_0000, 32'sh0001_0000};
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        begin_test("reset state");
        expect_level("in_ready", 1'b1, in_ready);
        expect_level("out_valid", 1'b0, out_valid);
        expect_level("busy", 1'b0, busy);
        finish_test();

        begin_test("identity rotation");
        set_identity();
        send_tri();
        lat = 0;
        while (!out_valid) begin
            @(negedge clk);
            lat++;
        end
        assert (lat == 7) else begin
            $display("ERR out_valid latency expected %h got %h", 7, lat);
            errors++;
        end
        assert (out_t == tri_v) else begin
            $display("ERR out_t expected %h got %h", tri_v, out_t);
            errors++;
        end
        drain();
        finish_test();

        begin_test("identity with position");
        pos_v = {32'sh0001_2345, 32'shFFFF_8000, 32'sh7FFF_0000};
        send_tri();
        drain();
        finish_test();

        begin_test("single axis 90 degrees");
        for (int axis = 0; axis < 3; axis++) begin
            set_identity();
            rot_v[2*axis]   = xform_pkg::q_one;
            rot_v[2*axis+1] = '0;
            send_tri();
        end
        drain();
        finish_test();

        begin_test("random back to back");
        for (int n = 0; n < n_rand; n++) begin
            random_triangle();
            send_tri();
        end
        drain();
        finish_test();

        begin_test("random out_ready");
        random_ready = 1'b1;
        for (int n = 0; n < n_rand; n++) begin
            random_triangle();
            send_tri();
        end
        drain();
        random_ready = 1'b0;
        finish_test();

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 test_pass, test_fail, errors);
        if (errors == 0 && test_fail == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+sim
src/xform_pkg.sv
src/rot_matrix_builder.sv
src/vertex_sequencer.sv
src/vertex_transform.sv
src/triangle_assembler.sv
src/model_world_transformer.sv
sim/tb_model_world_transformer.sv

//--- Makefile
TOP := tb_model_world_transformer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
